/* logic/regwin_pkg.sv */
// shared sizes and types for a four window register file; NUM_GROUPS must stay 2*NUM_WINDOWS+1
`default_nettype none

package regwin_pkg;

	// register width and window geometry
	localparam int DATA_W         = 32;
	localparam int NUM_WINDOWS    = 4;
	localparam int REGS_PER_GROUP = 8;

	// globals plus outs and locals of every window
	localparam int NUM_GROUPS     = 2 * NUM_WINDOWS + 1;

	localparam int CWP_W          = $clog2(NUM_WINDOWS);
	localparam int GROUP_W        = $clog2(NUM_GROUPS);
	localparam int SLOT_W         = $clog2(REGS_PER_GROUP);

	// window command, sampled every cycle
	typedef enum logic [1:0] {
		win_none    = 2'd0,
		win_save    = 2'd1,
		win_restore = 2'd2
	} win_op_e;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [CWP_W-1:0]  cwp_t;

	// write request broadcast to every group
	typedef struct packed {
		logic [NUM_GROUPS-1:0] grp_en;
		logic [SLOT_W-1:0]     slot;
		data_t                 data;
	} wr_req_t;

	// read selection toward the output mux
	typedef struct packed {
		logic [GROUP_W-1:0] grp;
		logic [SLOT_W-1:0]  slot;
		// set for r0
		logic               zero;
		logic               strobe;
	} rd_sel_t;

	// contents of one group, slot 0 at the low end
	typedef data_t [REGS_PER_GROUP-1:0] group_data_t;

endpackage

`default_nettype wire

/* logic/window_ctrl.sv */
// save at full depth or restore at zero depth is refused and flagged; no spill or fill
`default_nettype none

module window_ctrl (
	input  wire                    clk,
	input  wire                    rst_n,
	input  regwin_pkg::win_op_e    win_cmd,
	output regwin_pkg::cwp_t       cwp,
	output logic                   overflow,
	output logic                   underflow
);

	import regwin_pkg::*;

	// number of nested saves currently live
	logic [CWP_W:0] depth;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cwp       <= '0;
			depth     <= '0;
			overflow  <= 1'b0;
			underflow <= 1'b0;
		end else begin
			overflow  <= 1'b0;
			underflow <= 1'b0;
			case (win_cmd)
				win_save: begin
					if (depth == (CWP_W + 1)'(NUM_WINDOWS - 1)) begin
						overflow <= 1'b1;
					end else begin
						// save moves to the next lower window
						cwp   <= cwp - 1'b1;
						depth <= depth + 1'b1;
					end
				end
				win_restore: begin
					if (depth == '0) begin
						underflow <= 1'b1;
					end else begin
						cwp   <= cwp + 1'b1;
						depth <= depth - 1'b1;
					end
				end
				default: begin
					// no window change
				end
			endcase
		end
	end

	// depth counter must stay inside the window ring
	a_depth_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		depth <= (CWP_W + 1)'(NUM_WINDOWS - 1)
	) else $error("window depth %0d exceeds ring", depth);

endmodule

`default_nettype wire

/* logic/window_decoder.sv */
// purely combinational; the caller's cwp is used as is, so a same-cycle save sees the old window
`default_nettype none

module window_decoder (
	input  regwin_pkg::cwp_t      cwp,
	input  wire                   enable,
	input  wire                   rw,
	input  wire  [4:0]            r_num,
	input  regwin_pkg::data_t     wr_data,
	output regwin_pkg::wr_req_t   wr_req,
	output regwin_pkg::rd_sel_t   rd_sel
);

	import regwin_pkg::*;

	// windowed group before the global offset
	logic [GROUP_W:0]   win_sum;
	logic [GROUP_W-1:0] phys_grp;
	logic               is_r0;

	always_comb begin
		// outs at 2*cwp, locals at 2*cwp+1, ins at 2*cwp+2
		win_sum = (GROUP_W + 1)'(cwp) * 2 + (GROUP_W + 1)'(r_num[4:3]) - 1'b1;
		if (r_num[4:3] == 2'b00) begin
			phys_grp = '0;
		end else begin
			// ins of the last window wrap onto the outs of window 0
			phys_grp = GROUP_W'(win_sum % (NUM_GROUPS - 1)) + 1'b1;
		end
		is_r0 = (r_num == 5'd0);
	end

	always_comb begin
		wr_req.grp_en = '0;
		// r0 is never written
		if (enable && rw && !is_r0) begin
			wr_req.grp_en = NUM_GROUPS'(1) << phys_grp;
		end
		wr_req.slot = r_num[SLOT_W-1:0];
		wr_req.data = wr_data;
	end

	always_comb begin
		rd_sel.grp    = phys_grp;
		rd_sel.slot   = r_num[SLOT_W-1:0];
		rd_sel.zero   = is_r0;
		rd_sel.strobe = enable && !rw;
	end

	// at most one physical group may take a write
	always_comb begin
		a_onehot_en: assert #0 ($onehot0(wr_req.grp_en))
			else $error("more than one group enabled: %b", wr_req.grp_en);
	end

endmodule

`default_nettype wire

/* logic/reg_group.sv */
// eight registers of one group; clr and reset both zero every slot at the clock edge
`default_nettype none

module reg_group (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire                              clr,
	input  wire  [regwin_pkg::GROUP_W-1:0]   index,
	input  regwin_pkg::wr_req_t              wr_req,
	output regwin_pkg::group_data_t          regs
);

	import regwin_pkg::*;

	// this group's bit of the one-hot enable
	logic wr_en;

	assign wr_en = wr_req.grp_en[index];

	always_ff @(posedge clk) begin
		if (!rst_n || clr) begin
			regs <= '0;
		end else if (wr_en) begin
			regs[wr_req.slot] <= wr_req.data;
		end
	end

endmodule

`default_nettype wire

/* logic/window_read_mux.sv */
// rd_data updates only on a read strobe and is held between reads; r0 is forced to zero here
`default_nettype none

module window_read_mux (
	input  wire                       clk,
	input  wire                       rst_n,
	input  regwin_pkg::rd_sel_t       rd_sel,
	input  regwin_pkg::group_data_t   groups [regwin_pkg::NUM_GROUPS],
	output regwin_pkg::data_t         rd_data,
	output logic                      rd_valid
);

	import regwin_pkg::*;

	// addressed word before the output register
	data_t sel_word;

	always_comb begin
		if (rd_sel.zero) begin
			sel_word = '0;
		end else begin
			sel_word = groups[rd_sel.grp][rd_sel.slot];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_data  <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_sel.strobe;
			if (rd_sel.strobe) begin
				rd_data <= sel_word;
			end
		end
	end

	// valid only follows a read strobe by one cycle
	a_valid_after_strobe: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd_valid |-> $past(rd_sel.strobe)
	) else $error("rd_valid without a preceding read strobe");

	// the decoder never addresses a group past the last one
	a_grp_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd_sel.strobe |-> (rd_sel.grp < GROUP_W'(NUM_GROUPS))
	) else $error("read of missing group %0d", rd_sel.grp);

endmodule

`default_nettype wire

/* logic/windowed_regfile.sv */
// single access port; a read result appears the cycle after the strobe with rd_valid high
`default_nettype none

module windowed_regfile (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      clr,
	input  wire                      enable,
	input  wire                      rw,
	input  wire  [4:0]               r_num,
	input  regwin_pkg::data_t        wr_data,
	input  regwin_pkg::win_op_e      win_cmd,
	output regwin_pkg::data_t        rd_data,
	output logic                     rd_valid,
	output regwin_pkg::cwp_t         cwp,
	output logic                     overflow,
	output logic                     underflow
);

	import regwin_pkg::*;

	wr_req_t     wr_req;
	rd_sel_t     rd_sel;
	group_data_t group_data [NUM_GROUPS];

	window_ctrl u_window_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.win_cmd   (win_cmd),
		.cwp       (cwp),
		.overflow  (overflow),
		.underflow (underflow)
	);

	window_decoder u_window_decoder (
		.cwp     (cwp),
		.enable  (enable),
		.rw      (rw),
		.r_num   (r_num),
		.wr_data (wr_data),
		.wr_req  (wr_req),
		.rd_sel  (rd_sel)
	);

	// group 0 holds the globals, 1 to 8 the windowed groups
	for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
		reg_group u_reg_group (
			.clk    (clk),
			.rst_n  (rst_n),
			.clr    (clr),
			.index  (GROUP_W'(g)),
			.wr_req (wr_req),
			.regs   (group_data[g])
		);
	end

	window_read_mux u_window_read_mux (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_sel   (rd_sel),
		.groups   (group_data),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

endmodule

`default_nettype wire

/* verification/tb_windowed_regfile.sv */
// reads verification/regfile_input.txt from the project root; one step per line, two cycles per step
`default_nettype none

module tb_windowed_regfile;
	timeunit 1ns;
	timeprecision 100ps;

	import regwin_pkg::*;

	localparam int CLK_PERIOD  = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int RD_TIMEOUT  = 8;
	localparam int MAX_STEPS   = 256;

	logic       clk;
	logic       rst_n;
	logic       clr;
	logic       enable;
	logic       rw;
	logic [4:0] r_num;
	data_t      wr_data;
	win_op_e    win_cmd;
	data_t      rd_data;
	logic       rd_valid;
	cwp_t       cwp;
	logic       overflow;
	logic       underflow;

	int data_errors;
	int cwp_errors;
	int flag_errors;
	int other_errors;

	windowed_regfile u_windowed_regfile (
		.clk       (clk),
		.rst_n     (rst_n),
		.clr       (clr),
		.enable    (enable),
		.rw        (rw),
		.r_num     (r_num),
		.wr_data   (wr_data),
		.win_cmd   (win_cmd),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.cwp       (cwp),
		.overflow  (overflow),
		.underflow (underflow)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			data_errors++;
		end
	endtask

	task automatic check_cwp(input string name, input cwp_t expected, input cwp_t actual);
		if (actual !== expected) begin
			$display("FAIL %s cwp: expected %0d, actual %0d", name, expected, actual);
			cwp_errors++;
		end
	endtask

	task automatic check_flag(input string name, input string which, input logic expected,
			input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s %s: expected %b, actual %b", name, which, expected, actual);
			flag_errors++;
		end
	endtask

	// all access inputs quiet
	task automatic drive_idle();
		clr     = 1'b0;
		enable  = 1'b0;
		rw      = 1'b0;
		r_num   = 5'd0;
		wr_data = '0;
		win_cmd = win_none;
	endtask

	// op 1 read, 2 write, 3 clear, anything else idle
	task automatic drive_step(input int op, input int win, input int reg_num, input data_t data);
		drive_idle();
		case (op)
			1: begin
				enable = 1'b1;
				rw     = 1'b0;
			end
			2: begin
				enable = 1'b1;
				rw     = 1'b1;
			end
			3: begin
				clr = 1'b1;
			end
			default: begin
			end
		endcase
		win_cmd = win_op_e'(win[1:0]);
		r_num   = reg_num[4:0];
		wr_data = data;
	endtask

	// sampled one drive delay after each edge
	task automatic wait_rd_valid(output int waited, output bit timed_out);
		waited    = 0;
		timed_out = 1'b0;
		while (!rd_valid && waited < RD_TIMEOUT) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			waited++;
		end
		if (!rd_valid) begin
			timed_out = 1'b1;
		end
	endtask

	initial begin
		int    fd;
		int    n;
		int    step;
		int    op;
		int    win;
		int    reg_num;
		int    exp_cwp;
		int    exp_ovf;
		int    exp_unf;
		int    waited;
		bit    timed_out;
		bit    abort;
		string line;
		string tag;
		string name;
		data_t wdata;
		data_t exp_data;

		data_errors  = 0;
		cwp_errors   = 0;
		flag_errors  = 0;
		other_errors = 0;
		step         = 0;
		abort        = 1'b0;
		drive_idle();
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;

		// state straight out of reset
		check_cwp("reset", '0, cwp);
		check_flag("reset", "rd_valid", 1'b0, rd_valid);
		check_flag("reset", "overflow", 1'b0, overflow);
		check_flag("reset", "underflow", 1'b0, underflow);
		check_data("reset rd_data", '0, rd_data);

		fd = $fopen("verification/regfile_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file verification/regfile_input.txt");
			other_errors++;
		end else begin
			while (!$feof(fd) && !abort && step < MAX_STEPS) begin
				line = "";
				n = $fgets(line, fd);
				// skip blank and comment lines
				if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%s %d %d %d %h %h %d %d %d", tag, op, win, reg_num,
					wdata, exp_data, exp_cwp, exp_ovf, exp_unf);
				if (n != 9) begin
					$display("stimulus line could not be parsed: %s", line);
					other_errors++;
					continue;
				end
				step++;
				name = $sformatf("%s step %0d", tag, step);

				drive_step(op, win, reg_num, wdata);
				@(posedge clk);
				#(DRIVE_DELAY);
				drive_idle();

				// one cycle after the sampling edge
				check_cwp(name, cwp_t'(exp_cwp), cwp);
				check_flag(name, "overflow", exp_ovf[0], overflow);
				check_flag(name, "underflow", exp_unf[0], underflow);
				if (op == 1) begin
					wait_rd_valid(waited, timed_out);
					if (timed_out) begin
						$display("rd_valid never arrived after the read in %s", name);
						other_errors++;
						abort = 1'b1;
					end else begin
						if (waited != 0) begin
							$display("rd_valid came %0d cycles late in %s", waited, name);
							flag_errors++;
						end
						check_data(name, exp_data, rd_data);
					end
				end else begin
					check_flag(name, "rd_valid", 1'b0, rd_valid);
				end

				// pulses are over and read data holds
				if (!abort) begin
					@(posedge clk);
					#(DRIVE_DELAY);
					check_flag(name, "rd_valid next cycle", 1'b0, rd_valid);
					check_flag(name, "overflow next cycle", 1'b0, overflow);
					check_flag(name, "underflow next cycle", 1'b0, underflow);
					if (op == 1) begin
						check_data({name, " held"}, exp_data, rd_data);
					end
				end
			end
			$fclose(fd);
			if (step == 0) begin
				$display("the stimulus file held no steps");
				other_errors++;
			end
		end

		$display("errors: data %0d, cwp %0d, flag %0d, other %0d over %0d steps",
			data_errors, cwp_errors, flag_errors, other_errors, step);
		if (data_errors + cwp_errors + flag_errors + other_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/regfile_input.txt */
# columns: tag op win reg wdata exp_data exp_cwp exp_ovf exp_unf
# op 0 idle 1 read 2 write 3 clr, win 0 none 1 save 2 restore, reg decimal, data hex
glob 2 0 1 11111111 00000000 0 0 0
glob 2 0 7 77777777 00000000 0 0 0
glob 2 0 0 deadbeef 00000000 0 0 0
glob 1 0 0 00000000 00000000 0 0 0
glob 1 0 1 00000000 11111111 0 0 0
ovl 2 0 8 a0000008 00000000 0 0 0
ovl 2 0 15 a000000f 00000000 0 0 0
loc 2 0 16 10c00010 00000000 0 0 0
ovl 2 1 9 a0000009 00000000 3 0 0
ovl 1 0 24 00000000 a0000008 3 0 0
ovl 1 0 31 00000000 a000000f 3 0 0
ovl 1 0 25 00000000 a0000009 3 0 0
glob 1 0 1 00000000 11111111 3 0 0
loc 1 0 16 00000000 00000000 3 0 0
loc 2 0 16 30c00010 00000000 3 0 0
depth 0 1 0 00000000 00000000 2 0 0
glob 1 0 7 00000000 77777777 2 0 0
loc 1 0 16 00000000 00000000 2 0 0
ovl 1 0 24 00000000 00000000 2 0 0
ovl 2 0 8 b2000008 00000000 2 0 0
depth 0 1 0 00000000 00000000 1 0 0
ovl 1 0 24 00000000 b2000008 1 0 0
ovl 1 0 8 00000000 00000000 1 0 0
glob 1 0 1 00000000 11111111 1 0 0
depth 0 1 0 00000000 00000000 1 1 0
depth 0 2 0 00000000 00000000 2 0 0
ovl 1 0 8 00000000 b2000008 2 0 0
depth 0 2 0 00000000 00000000 3 0 0
loc 1 2 16 00000000 30c00010 0 0 0
loc 1 0 16 00000000 10c00010 0 0 0
ovl 1 0 8 00000000 a0000008 0 0 0
ovl 1 0 9 00000000 a0000009 0 0 0
ovl 1 0 15 00000000 a000000f 0 0 0
depth 0 2 0 00000000 00000000 0 0 1
glob 1 0 7 00000000 77777777 0 0 0
depth 0 1 0 00000000 00000000 3 0 0
clr 3 0 0 00000000 00000000 3 0 0
clr 1 0 1 00000000 00000000 3 0 0
clr 1 0 16 00000000 00000000 3 0 0
clr 1 0 25 00000000 00000000 3 0 0
clr 1 0 31 00000000 00000000 3 0 0
depth 0 2 0 00000000 00000000 0 0 0
clr 1 0 7 00000000 00000000 0 0 0
clr 1 0 8 00000000 00000000 0 0 0
clr 1 0 16 00000000 00000000 0 0 0

/* tb.f */
logic/regwin_pkg.sv
logic/window_ctrl.sv
logic/window_decoder.sv
logic/reg_group.sv
logic/window_read_mux.sv
logic/windowed_regfile.sv
verification/tb_windowed_regfile.sv

/* Bender.yml */
package:
  name: windowed_regfile

sources:
  - logic/regwin_pkg.sv
  - logic/window_ctrl.sv
  - logic/window_decoder.sv
  - logic/reg_group.sv
  - logic/window_read_mux.sv
  - logic/windowed_regfile.sv
  - target: simulation
    files:
      - verification/tb_windowed_regfile.sv
